/* Bender.yml */
package:
  name: hart

export_include_dirs:
  - common

sources:
  - common/hart_pkg.sv
  - common/issue_if.sv
  - hdl/fetch_stage.sv
  - decode/reg_file.sv
  - decode/decode_stage.sv
  - execute/execute_stage.sv
  - hdl/hart.sv
  - target: test
    files:
      - tests/hart_properties.sv
      - tests/hart_tb.sv

/* common/hart_consts.svh */
`ifndef HART_CONSTS_SVH
`define HART_CONSTS_SVH

// data path and address width of the hart
`define XLEN 32

// a register index selects one of 32 architectural registers
`define REG_ADDR_W 5

// first fetch address once reset releases
`define RESET_ADDR 32'h0000_0000

// ebreak is the only SYSTEM encoding the decoder accepts, and it reports halt
`define EBREAK_WORD 32'h0010_0073

// addi x0, x0, 0 fills a pipeline slot that holds no instruction
`define NOP_WORD 32'h0000_0013

`endif

/* common/hart_pkg.sv */
`default_nettype none

package hart_pkg;

  // major opcodes the hart decodes, anything else is illegal
  typedef enum logic [6:0] {
    OP     = 7'b0110011,  // register-register integer ops
    OP_IMM = 7'b0010011,  // register-immediate integer ops
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,  // only lw is accepted
    STORE  = 7'b0100011,  // only sw is accepted
    SYSTEM = 7'b1110011   // only ebreak is accepted
  } opcode_e;

  // ALU_ADD sits at zero so a cleared bundle selects add
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9
  } alu_op_e;

  // control bundle produced by decode and consumed by execute
  typedef struct packed {
    alu_op_e alu_op;
    logic    use_imm;    // operand 2 is the immediate instead of rs2
    logic    is_lui;     // writeback takes the U immediate
    logic    is_load;
    logic    is_store;
    logic    is_halt;    // ebreak
    logic    illegal;    // encoding not supported, retires as a trap
    logic    reg_write;  // instruction has a destination register
    logic    uses_rs1;
    logic    uses_rs2;
  } ctrl_t;

endpackage

`default_nettype wire

/* common/issue_if.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hart_consts.svh"

// one decoded instruction on its way from decode into execute
interface issue_if;
  import hart_pkg::*;

  logic              valid;     // slot holds a real instruction
  logic [`XLEN-1:0]  pc;        // fetch address of the instruction
  logic [`XLEN-1:0]  inst;      // raw instruction word, nop when not valid
  ctrl_t             ctrl;      // decoded control bundle
  logic [`XLEN-1:0]  rs1_data;  // zero when rs1 is not used
  logic [`XLEN-1:0]  rs2_data;  // zero when rs2 is not used
  logic [`XLEN-1:0]  imm;       // I, S or U immediate picked by the opcode

  // decode fills the register at the edge that ends its cycle
  modport decode (
    output valid, pc, inst, ctrl, rs1_data, rs2_data, imm
  );

  // execute uses the registered values for the whole following cycle
  modport execute (
    input valid, pc, inst, ctrl, rs1_data, rs2_data, imm
  );

endinterface

`default_nettype wire

/* compile.f */
+incdir+common
common/hart_pkg.sv
common/issue_if.sv
hdl/fetch_stage.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
hdl/hart.sv
tests/hart_properties.sv
tests/hart_tb.sv

/* decode/decode_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hart_consts.svh"

module decode_stage (
  input  wire                    i_clk,
  input  wire                    i_rst,
  input  wire                    i_valid,     // from the fetch register
  input  wire  [`XLEN-1:0]       i_pc,
  input  wire  [`XLEN-1:0]       i_inst,
  input  wire                    i_wb_wen,    // writeback from execute, same cycle
  input  wire  [`REG_ADDR_W-1:0] i_wb_waddr,
  input  wire  [`XLEN-1:0]       i_wb_wdata,
  issue_if.decode                o_issue
);
  import hart_pkg::*;

  logic [6:0]             func7;
  logic [2:0]             func3;
  logic [`REG_ADDR_W-1:0] rs1_idx;     // index after masking unused sources
  logic [`REG_ADDR_W-1:0] rs2_idx;
  logic [`XLEN-1:0]       rs1_rdata;
  logic [`XLEN-1:0]       rs2_rdata;
  logic [`XLEN-1:0]       imm;
  opcode_e                opcode;
  ctrl_t                  ctrl;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign func3  = i_inst[14:12];
  assign func7  = i_inst[31:25];

  always_comb begin
    ctrl        = '0;       // add, no effects, nothing read or written
    case (opcode)
      OP: begin
        ctrl.uses_rs1  = 1'b1;
        ctrl.uses_rs2  = 1'b1;
        ctrl.reg_write = 1'b1;
        case ({func7, func3})
          10'b0000000_000: ctrl.alu_op = ALU_ADD;
          10'b0100000_000: ctrl.alu_op = ALU_SUB;
          10'b0000000_001: ctrl.alu_op = ALU_SLL;
          10'b0000000_010: ctrl.alu_op = ALU_SLT;
          10'b0000000_011: ctrl.alu_op = ALU_SLTU;
          10'b0000000_100: ctrl.alu_op = ALU_XOR;
          10'b0000000_101: ctrl.alu_op = ALU_SRL;
          10'b0100000_101: ctrl.alu_op = ALU_SRA;
          10'b0000000_110: ctrl.alu_op = ALU_OR;
          10'b0000000_111: ctrl.alu_op = ALU_AND;
          default:         ctrl.illegal = 1'b1;  // any other func7 pattern
        endcase
      end
      OP_IMM: begin
        ctrl.uses_rs1  = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
        case (func3)
          3'b000:  ctrl.alu_op = ALU_ADD;
          3'b010:  ctrl.alu_op = ALU_SLT;
          3'b011:  ctrl.alu_op = ALU_SLTU;
          3'b100:  ctrl.alu_op = ALU_XOR;
          3'b110:  ctrl.alu_op = ALU_OR;
          3'b111:  ctrl.alu_op = ALU_AND;
          // shift immediates keep func7 in the upper immediate bits
          3'b001:  if (func7 == 7'b0000000) ctrl.alu_op = ALU_SLL;
                   else ctrl.illegal = 1'b1;
          default: begin
            if (func7 == 7'b0000000)      ctrl.alu_op  = ALU_SRL;
            else if (func7 == 7'b0100000) ctrl.alu_op  = ALU_SRA;
            else                          ctrl.illegal = 1'b1;
          end
        endcase
      end
      LUI: begin
        ctrl.is_lui    = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      LOAD: begin
        ctrl.is_load   = (func3 == 3'b010);  // word only
        ctrl.illegal   = (func3 != 3'b010);
        ctrl.uses_rs1  = ctrl.is_load;
        ctrl.use_imm   = ctrl.is_load;
        ctrl.reg_write = ctrl.is_load;
      end
      STORE: begin
        ctrl.is_store = (func3 == 3'b010);
        ctrl.illegal  = (func3 != 3'b010);
        ctrl.uses_rs1 = ctrl.is_store;
        ctrl.uses_rs2 = ctrl.is_store;
        ctrl.use_imm  = ctrl.is_store;
      end
      SYSTEM:  begin
        ctrl.is_halt = (i_inst == `EBREAK_WORD);
        ctrl.illegal = (i_inst != `EBREAK_WORD);  // ecall and csr ops are not supported
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

  // S splits its immediate around rd, U fills the upper 20 bits, all others use I
  always_comb begin
    case (opcode)
      STORE:   imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
      LUI:     imm = {i_inst[31:12], 12'b0};
      default: imm = {{20{i_inst[31]}}, i_inst[31:20]};
    endcase
  end

  // an unused source reads x0, so both its index and its data come out zero
  assign rs1_idx = ctrl.uses_rs1 ? i_inst[19:15] : '0;
  assign rs2_idx = ctrl.uses_rs2 ? i_inst[24:20] : '0;

  reg_file u_reg_file (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rs1_raddr (rs1_idx),
    .i_rs2_raddr (rs2_idx),
    .o_rs1_rdata (rs1_rdata),
    .o_rs2_rdata (rs2_rdata),
    .i_rd_wen    (i_wb_wen),
    .i_rd_waddr  (i_wb_waddr),
    .i_rd_wdata  (i_wb_wdata)
  );

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_issue.valid <= 1'b0;
      o_issue.ctrl  <= '0;
    end else begin
      o_issue.valid <= i_valid;
      o_issue.ctrl  <= i_valid ? ctrl : '0;  // an empty slot carries no control
    end
  end

  always_ff @(posedge i_clk) begin
    o_issue.pc       <= i_pc;
    o_issue.inst     <= i_valid ? i_inst : `NOP_WORD;
    o_issue.rs1_data <= rs1_rdata;
    o_issue.rs2_data <= rs2_rdata;
    o_issue.imm      <= imm;
  end

endmodule

`default_nettype wire

/* decode/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hart_consts.svh"

module reg_file (
  input  wire                    i_clk,
  input  wire                    i_rst,
  input  wire  [`REG_ADDR_W-1:0] i_rs1_raddr,
  input  wire  [`REG_ADDR_W-1:0] i_rs2_raddr,
  output logic [`XLEN-1:0]       o_rs1_rdata,
  output logic [`XLEN-1:0]       o_rs2_rdata,
  input  wire                    i_rd_wen,
  input  wire  [`REG_ADDR_W-1:0] i_rd_waddr,
  input  wire  [`XLEN-1:0]       i_rd_wdata
);

  // x0 has no storage, it is decoded to zero on the read side
  logic [`XLEN-1:0] regs [1:31];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd_waddr != '0)) begin
      regs[i_rd_waddr] <= i_rd_wdata;  // writes to x0 are dropped here
    end
  end

  // write data goes straight through to a read of the same register, so a
  // dependent instruction in decode never has to wait for the edge
  function automatic logic [`XLEN-1:0] read_port(input logic [`REG_ADDR_W-1:0] addr);
    if (addr == '0)
      return '0;
    else if (i_rd_wen && (addr == i_rd_waddr))
      return i_rd_wdata;
    else
      return regs[addr];
  endfunction

  // both ports follow the array and the write port as well as their own index
  always_comb begin
    o_rs1_rdata = read_port(i_rs1_raddr);
    o_rs2_rdata = read_port(i_rs2_raddr);
  end

endmodule

`default_nettype wire

/* execute/execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hart_consts.svh"

module execute_stage (
  issue_if.execute               i_issue,
  output logic [`XLEN-1:0]       o_dmem_addr,
  output logic                   o_dmem_ren,    // combinational read this cycle
  output logic                   o_dmem_wen,    // write lands at the next edge
  output logic [`XLEN-1:0]       o_dmem_wdata,
  input  wire  [`XLEN-1:0]       i_dmem_rdata,
  output logic                   o_wb_wen,
  output logic [`REG_ADDR_W-1:0] o_wb_waddr,
  output logic [`XLEN-1:0]       o_wb_wdata,
  output logic                   o_retire_valid,
  output logic [`XLEN-1:0]       o_retire_inst,
  output logic                   o_retire_trap,
  output logic                   o_retire_halt,
  output logic [`REG_ADDR_W-1:0] o_retire_rs1_raddr,
  output logic [`REG_ADDR_W-1:0] o_retire_rs2_raddr,
  output logic [`XLEN-1:0]       o_retire_rs1_rdata,
  output logic [`XLEN-1:0]       o_retire_rs2_rdata,
  output logic [`REG_ADDR_W-1:0] o_retire_rd_waddr,
  output logic [`XLEN-1:0]       o_retire_rd_wdata,
  output logic [`XLEN-1:0]       o_retire_pc,
  output logic [`XLEN-1:0]       o_retire_next_pc
);
  import hart_pkg::*;

  logic [`XLEN-1:0] op1;
  logic [`XLEN-1:0] op2;
  logic [4:0]       shamt;
  logic [`XLEN-1:0] alu_result;
  logic             misaligned;
  logic             trap;
  ctrl_t            ctrl;

  assign ctrl  = i_issue.ctrl;
  assign op1   = i_issue.rs1_data;
  assign op2   = ctrl.use_imm ? i_issue.imm : i_issue.rs2_data;
  assign shamt = op2[4:0];  // only the low five bits count for a 32 bit shift

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_result = op1 + op2;
      ALU_SUB:  alu_result = op1 - op2;
      ALU_SLL:  alu_result = op1 << shamt;
      ALU_SLT:  alu_result = {31'b0, $signed(op1) < $signed(op2)};
      ALU_SLTU: alu_result = {31'b0, op1 < op2};
      ALU_XOR:  alu_result = op1 ^ op2;
      ALU_SRL:  alu_result = op1 >> shamt;
      ALU_SRA:  alu_result = $unsigned($signed(op1) >>> shamt);
      ALU_OR:   alu_result = op1 | op2;
      ALU_AND:  alu_result = op1 & op2;
      default:  alu_result = '0;
    endcase
  end

  // loads and stores decode to add with the immediate, so the ALU forms rs1 + imm
  assign o_dmem_addr  = alu_result;
  assign o_dmem_wdata = i_issue.rs2_data;

  // only whole words are supported, any byte offset within the word traps
  assign misaligned = (ctrl.is_load || ctrl.is_store) && (alu_result[1:0] != 2'b00);
  assign trap       = ctrl.illegal || misaligned;

  // a trapping instruction leaves memory and registers untouched
  assign o_dmem_ren = i_issue.valid && ctrl.is_load  && !trap;
  assign o_dmem_wen = i_issue.valid && ctrl.is_store && !trap;
  assign o_wb_wen   = i_issue.valid && ctrl.reg_write && !trap;

  assign o_wb_waddr = o_wb_wen ? i_issue.inst[11:7] : '0;  // zero whenever nothing is written
  assign o_wb_wdata = ctrl.is_load ? i_dmem_rdata :
                      ctrl.is_lui  ? i_issue.imm  : alu_result;

  assign o_retire_valid     = i_issue.valid;
  assign o_retire_inst      = i_issue.inst;
  assign o_retire_trap      = trap;
  assign o_retire_halt      = ctrl.is_halt;
  assign o_retire_rs1_raddr = ctrl.uses_rs1 ? i_issue.inst[19:15] : '0;
  assign o_retire_rs2_raddr = ctrl.uses_rs2 ? i_issue.inst[24:20] : '0;
  assign o_retire_rs1_rdata = i_issue.rs1_data;  // already zero for an unused source
  assign o_retire_rs2_rdata = i_issue.rs2_data;
  assign o_retire_rd_waddr  = o_wb_waddr;
  assign o_retire_rd_wdata  = o_wb_wdata;
  assign o_retire_pc        = i_issue.pc;
  assign o_retire_next_pc   = i_issue.pc + `XLEN'd4;  // nothing redirects the pc

endmodule

`default_nettype wire

/* hdl/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hart_consts.svh"

module fetch_stage (
  input  wire               i_clk,
  input  wire               i_rst,
  output logic [`XLEN-1:0]  o_imem_raddr,  // read address, straight from the pc register
  input  wire  [`XLEN-1:0]  i_imem_rdata,  // word at o_imem_raddr, same cycle
  output logic              o_valid,
  output logic [`XLEN-1:0]  o_pc,
  output logic [`XLEN-1:0]  o_inst
);

  logic [`XLEN-1:0] pc_q;

  // there are no branches or jumps so the pc only ever steps by one word
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q <= `RESET_ADDR;
    end else begin
      pc_q <= pc_q + `XLEN'd4;
    end
  end

  assign o_imem_raddr = pc_q;

  // the valid bit stays low through reset and the first cycle after it
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= 1'b1;  // every cycle after reset brings a new word
    end
  end

  // fetched word travels with its address
  always_ff @(posedge i_clk) begin
    o_pc   <= pc_q;
    o_inst <= i_imem_rdata;
  end

endmodule

`default_nettype wire

/* hdl/hart.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hart_consts.svh"

module hart (
  input  wire                    i_clk,
  input  wire                    i_rst,           // synchronous, active high
  output logic [`XLEN-1:0]       o_imem_raddr,
  input  wire  [`XLEN-1:0]       i_imem_rdata,
  output logic [`XLEN-1:0]       o_dmem_addr,     // always word aligned when enabled
  output logic                   o_dmem_ren,
  output logic                   o_dmem_wen,
  output logic [`XLEN-1:0]       o_dmem_wdata,
  input  wire  [`XLEN-1:0]       i_dmem_rdata,
  output logic                   o_retire_valid,
  output logic [`XLEN-1:0]       o_retire_inst,
  output logic                   o_retire_trap,
  output logic                   o_retire_halt,
  output logic [`REG_ADDR_W-1:0] o_retire_rs1_raddr,
  output logic [`REG_ADDR_W-1:0] o_retire_rs2_raddr,
  output logic [`XLEN-1:0]       o_retire_rs1_rdata,
  output logic [`XLEN-1:0]       o_retire_rs2_rdata,
  output logic [`REG_ADDR_W-1:0] o_retire_rd_waddr,
  output logic [`XLEN-1:0]       o_retire_rd_wdata,
  output logic [`XLEN-1:0]       o_retire_pc,
  output logic [`XLEN-1:0]       o_retire_next_pc
);

  logic                   fetch_valid;  // fetch register toward decode
  logic [`XLEN-1:0]       fetch_pc;
  logic [`XLEN-1:0]       fetch_inst;
  logic                   wb_wen;       // writeback path from execute to the register file
  logic [`REG_ADDR_W-1:0] wb_waddr;
  logic [`XLEN-1:0]       wb_wdata;

  issue_if u_issue ();

  fetch_stage u_fetch (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .o_imem_raddr (o_imem_raddr),
    .i_imem_rdata (i_imem_rdata),
    .o_valid      (fetch_valid),
    .o_pc         (fetch_pc),
    .o_inst       (fetch_inst)
  );

  decode_stage u_decode (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_valid    (fetch_valid),
    .i_pc       (fetch_pc),
    .i_inst     (fetch_inst),
    .i_wb_wen   (wb_wen),
    .i_wb_waddr (wb_waddr),
    .i_wb_wdata (wb_wdata),
    .o_issue    (u_issue.decode)
  );

  // execute is purely combinational, its register write closes the pipeline
  execute_stage u_execute (
    .i_issue            (u_issue.execute),
    .o_dmem_addr        (o_dmem_addr),
    .o_dmem_ren         (o_dmem_ren),
    .o_dmem_wen         (o_dmem_wen),
    .o_dmem_wdata       (o_dmem_wdata),
    .i_dmem_rdata       (i_dmem_rdata),
    .o_wb_wen           (wb_wen),
    .o_wb_waddr         (wb_waddr),
    .o_wb_wdata         (wb_wdata),
    .o_retire_valid     (o_retire_valid),
    .o_retire_inst      (o_retire_inst),
    .o_retire_trap      (o_retire_trap),
    .o_retire_halt      (o_retire_halt),
    .o_retire_rs1_raddr (o_retire_rs1_raddr),
    .o_retire_rs2_raddr (o_retire_rs2_raddr),
    .o_retire_rs1_rdata (o_retire_rs1_rdata),
    .o_retire_rs2_rdata (o_retire_rs2_rdata),
    .o_retire_rd_waddr  (o_retire_rd_waddr),
    .o_retire_rd_wdata  (o_retire_rd_wdata),
    .o_retire_pc        (o_retire_pc),
    .o_retire_next_pc   (o_retire_next_pc)
  );

endmodule

`default_nettype wire

/* tests/hart_properties.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hart_consts.svh"

module hart_properties (
  input wire                    i_clk,
  input wire                    i_rst,
  input wire                    i_dmem_ren,
  input wire                    i_dmem_wen,
  input wire [`XLEN-1:0]        i_dmem_addr,
  input wire                    i_retire_valid,
  input wire                    i_retire_trap,
  input wire [`REG_ADDR_W-1:0]  i_retire_rd_waddr
);

  int failures = 0;

  // a single port serves one access per cycle
  no_read_with_write: assert property (@(posedge i_clk) disable iff (i_rst)
      !(i_dmem_ren && i_dmem_wen))
    else begin
      failures++;
      $error("dmem read and write enabled in the same cycle");
    end

  // misaligned word accesses trap before they reach memory
  word_aligned_access: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_dmem_ren || i_dmem_wen) |-> (i_dmem_addr[1:0] == 2'b00))
    else begin
      failures++;
      $error("dmem access at an address that is not word aligned");
    end

  // one reset edge is enough to empty the issue slot
  quiet_in_reset: assert property (@(posedge i_clk) $past(i_rst) |-> !i_retire_valid)
    else begin
      failures++;
      $error("retire reported while reset was held");
    end

  trap_writes_nothing: assert property (@(posedge i_clk) disable iff (i_rst)
      (i_retire_valid && i_retire_trap) |-> (i_retire_rd_waddr == '0))
    else begin
      failures++;
      $error("trapping instruction reported a destination register");
    end

endmodule

bind hart hart_properties u_props (
  .i_clk             (i_clk),
  .i_rst             (i_rst),
  .i_dmem_ren        (o_dmem_ren),
  .i_dmem_wen        (o_dmem_wen),
  .i_dmem_addr       (o_dmem_addr),
  .i_retire_valid    (o_retire_valid),
  .i_retire_trap     (o_retire_trap),
  .i_retire_rd_waddr (o_retire_rd_waddr)
);

`default_nettype wire

/* tests/hart_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "hart_consts.svh"

module hart_tb;

  localparam int PROG_LEN   = 200;                    // random instructions before the ebreak
  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 64;                     // covers the load/store window at 0x100
  localparam int TIMEOUT    = PROG_LEN + 1 + 2 + 20;  // program, ebreak, pipeline fill, slack

  // one expected retire record as the ISA rules predict it
  typedef struct packed {
    logic [`XLEN-1:0] inst;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] next_pc;
    logic [`XLEN-1:0] rs1_rdata;
    logic [`XLEN-1:0] rs2_rdata;
    logic [`XLEN-1:0] rd_wdata;
    logic [`XLEN-1:0] addr;       // data memory address of a lw or sw
    logic [4:0]       rs1_raddr;
    logic [4:0]       rs2_raddr;
    logic [4:0]       rd_waddr;
    logic             legal;      // source fields are only defined for legal encodings
    logic             trap;
    logic             halt;
    logic             writes;     // rd_wdata only means something when a write happens
    logic             ren;
    logic             wen;
  } retire_t;

  logic             i_clk;
  logic             i_rst;
  logic [`XLEN-1:0] o_imem_raddr;
  logic [`XLEN-1:0] i_imem_rdata;
  logic [`XLEN-1:0] o_dmem_addr;
  logic             o_dmem_ren;
  logic             o_dmem_wen;
  logic [`XLEN-1:0] o_dmem_wdata;
  logic [`XLEN-1:0] i_dmem_rdata;
  logic             o_retire_valid;
  logic [`XLEN-1:0] o_retire_inst;
  logic             o_retire_trap;
  logic             o_retire_halt;
  logic [4:0]       o_retire_rs1_raddr;
  logic [4:0]       o_retire_rs2_raddr;
  logic [`XLEN-1:0] o_retire_rs1_rdata;
  logic [`XLEN-1:0] o_retire_rs2_rdata;
  logic [4:0]       o_retire_rd_waddr;
  logic [`XLEN-1:0] o_retire_rd_wdata;
  logic [`XLEN-1:0] o_retire_pc;
  logic [`XLEN-1:0] o_retire_next_pc;

  logic [`XLEN-1:0] prog [0:IMEM_WORDS-1];        // instruction memory, also the model's program
  logic [`XLEN-1:0] dmem [0:DMEM_WORDS-1];
  logic [`XLEN-1:0] model_dmem [0:DMEM_WORDS-1];  // architectural copy of dmem
  logic [`XLEN-1:0] model_regs [0:31];
  logic [`XLEN-1:0] model_pc;
  logic [31:0]      lfsr;
  logic             done;
  int               errors = 0;
  int               edges  = 0;                   // rising edges since reset release

  hart dut (.*);

  always #10 i_clk = ~i_clk;

  // both memories answer within the cycle, dmem takes writes at the rising edge
  assign i_imem_rdata = prog[o_imem_raddr[9:2]];
  assign i_dmem_rdata = dmem[o_dmem_addr[7:2]];

  always @(posedge i_clk) begin
    if (o_dmem_wen) begin
      dmem[o_dmem_addr[7:2]] <= o_dmem_wdata;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);  // galois form
  endfunction

  // one lfsr step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] want);
    if (got !== want) begin
      errors = errors + 1;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic build_program();
    logic [3:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic [11:0] off;
    for (int i = 0; i < PROG_LEN; i++) begin
      kind = 4'(take_bits(4));
      rd   = 5'(take_bits(3));  // x0 to x7 so neighbours depend on each other often
      rs1  = 5'(take_bits(3));
      rs2  = 5'(take_bits(3));
      f3   = 3'(take_bits(3));
      imm  = 12'(take_bits(12));
      off  = 12'h100 | 12'(take_bits(4) << 2);  // one of 16 aligned words in the window
      if (take_bits(3) == 0) off = off | 12'(take_bits(2));  // about one in eight is unaligned
      if (kind < 6) begin
        prog[i] = {((f3 == 3'd0 || f3 == 3'd5) && take_bits(1) != 0) ? 7'h20 : 7'h00,
                   rs2, rs1, f3, rd, 7'h33};
      end else if (kind < 10) begin
        if (f3 == 3'd1) imm[11:5] = 7'h00;
        if (f3 == 3'd5) imm[11:5] = imm[10] ? 7'h20 : 7'h00;  // srai or srli
        prog[i] = {imm, rs1, f3, rd, 7'h13};
      end else if (kind == 10) begin
        prog[i] = {imm, rs1, f3, rd, 7'h37};  // lui, upper bits come from the drawn fields
      end else if (kind < 13) begin
        prog[i] = {off, 5'd0, 3'b010, rd, 7'h03};
      end else if (kind < 15) begin
        prog[i] = {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'h23};
      end else begin
        case (take_bits(2))
          0:       prog[i] = {7'h01, rs2, rs1, f3, rd, 7'h33};  // M extension encoding
          1:       prog[i] = {off, 5'd0, 3'b000, rd, 7'h03};    // lb
          2:       prog[i] = 32'h0000_0073;                     // ecall
          default: prog[i] = {imm, rs1, f3, rd, 7'h6f};         // jal
        endcase
      end
    end
    prog[PROG_LEN] = `EBREAK_WORD;
    for (int i = PROG_LEN + 1; i < IMEM_WORDS; i++) begin
      prog[i] = {25'(i), 7'h7f};  // padding words decode as illegal
    end
  endtask

  function automatic logic [`XLEN-1:0] compute_op(input logic [2:0] f3, input logic alt,
                                                  input logic [`XLEN-1:0] a,
                                                  input logic [`XLEN-1:0] b);
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'b0, $signed(a) < $signed(b)};
      3'd3:    return {31'b0, a < b};
      3'd4:    return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> b[4:0];
        else     return a >> b[4:0];
      end
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  // runs one instruction on the architectural model and returns what should retire
  function automatic retire_t reference_step();
    logic [`XLEN-1:0] w;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] imm_i;
    logic [2:0]       f3;
    logic [6:0]       f7;
    logic             use1;
    logic             use2;
    logic             is_ld;
    logic             is_st;
    logic             wr;
    retire_t          r;
    w     = prog[model_pc[9:2]];
    f3    = w[14:12];
    f7    = w[31:25];
    a     = model_regs[w[19:15]];
    b     = model_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    r     = '0;
    {use1, use2, is_ld, is_st, wr} = '0;
    case (w[6:0])
      7'h33: begin
        r.legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        {use1, use2, wr} = 3'b111;
        r.rd_wdata = compute_op(f3, f7[5], a, b);
      end
      7'h13: begin
        if (f3 == 3'd1)      r.legal = (f7 == 7'h00);
        else if (f3 == 3'd5) r.legal = (f7 == 7'h00 || f7 == 7'h20);
        else                 r.legal = 1'b1;
        {use1, wr} = 2'b11;
        r.rd_wdata = compute_op(f3, f3 == 3'd5 && f7[5], a, imm_i);
      end
      7'h37: begin
        {r.legal, wr} = 2'b11;
        r.rd_wdata = {w[31:12], 12'b0};
      end
      7'h03: begin
        r.legal = (f3 == 3'd2);  // word loads only
        {use1, wr, is_ld} = {3{r.legal}};
      end
      7'h23: begin
        r.legal = (f3 == 3'd2);
        {use1, use2, is_st} = {3{r.legal}};
      end
      7'h73:   r.legal = (w == `EBREAK_WORD);
      default: r.legal = 1'b0;
    endcase
    r.addr = a + (is_st ? {{20{w[31]}}, w[31:25], w[11:7]} : imm_i);
    if (is_ld) r.rd_wdata = model_dmem[r.addr[7:2]];
    r.trap      = !r.legal || ((is_ld || is_st) && r.addr[1:0] != 2'b00);
    r.halt      = (w == `EBREAK_WORD);
    r.writes    = wr && !r.trap;
    r.ren       = is_ld && !r.trap;
    r.wen       = is_st && !r.trap;
    r.inst      = w;
    r.pc        = model_pc;
    r.next_pc   = model_pc + 32'd4;
    r.rs1_raddr = use1 ? w[19:15] : 5'd0;
    r.rs2_raddr = use2 ? w[24:20] : 5'd0;
    r.rs1_rdata = use1 ? a : '0;
    r.rs2_rdata = use2 ? b : '0;
    r.rd_waddr  = r.writes ? w[11:7] : 5'd0;
    if (r.writes && w[11:7] != 5'd0) model_regs[w[11:7]] = r.rd_wdata;  // x0 stays zero
    if (r.wen) model_dmem[r.addr[7:2]] = b;
    model_pc = model_pc + 32'd4;
    return r;
  endfunction

  // compares every retire with the model, then the memories once the ebreak retires
  always @(posedge i_clk) begin
    retire_t exp_r;
    if (!i_rst && !done) begin
      edges = edges + 1;
      check_value("o_retire_valid", o_retire_valid, edges >= 3);
      check_value("o_imem_raddr", o_imem_raddr, `RESET_ADDR + 32'(4 * (edges - 1)));
      if (o_retire_valid) begin
        exp_r = reference_step();
        check_value("o_retire_inst", o_retire_inst, exp_r.inst);
        check_value("o_retire_pc", o_retire_pc, exp_r.pc);
        check_value("o_retire_next_pc", o_retire_next_pc, exp_r.next_pc);
        check_value("o_retire_trap", o_retire_trap, exp_r.trap);
        check_value("o_retire_halt", o_retire_halt, exp_r.halt);
        check_value("o_retire_rd_waddr", o_retire_rd_waddr, exp_r.rd_waddr);
        check_value("o_dmem_ren", o_dmem_ren, exp_r.ren);
        check_value("o_dmem_wen", o_dmem_wen, exp_r.wen);
        if (exp_r.legal) begin
          check_value("o_retire_rs1_raddr", o_retire_rs1_raddr, exp_r.rs1_raddr);
          check_value("o_retire_rs2_raddr", o_retire_rs2_raddr, exp_r.rs2_raddr);
          check_value("o_retire_rs1_rdata", o_retire_rs1_rdata, exp_r.rs1_rdata);
          check_value("o_retire_rs2_rdata", o_retire_rs2_rdata, exp_r.rs2_rdata);
        end
        if (exp_r.writes) check_value("o_retire_rd_wdata", o_retire_rd_wdata, exp_r.rd_wdata);
        if (exp_r.ren || exp_r.wen) check_value("o_dmem_addr", o_dmem_addr, exp_r.addr);
        if (exp_r.wen) check_value("o_dmem_wdata", o_dmem_wdata, exp_r.rs2_rdata);
        if (exp_r.halt) begin
          for (int k = 0; k < DMEM_WORDS; k++) begin
            check_value($sformatf("dmem[%0d]", k), dmem[k], model_dmem[k]);
          end
          done = 1'b1;
        end
      end
      if (!done && edges >= TIMEOUT) begin
        $display("timeout, the program never halted within %0d cycles", TIMEOUT);
        errors = errors + 1;
        done   = 1'b1;
      end
    end
  end

  initial begin
    i_clk    = 1'b0;
    i_rst    = 1'b1;
    done     = 1'b0;
    lfsr     = 32'h60de404a;
    model_pc = `RESET_ADDR;
    build_program();
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i]       = 32'h9e37_79b9 * 32'(i + 1);  // every word differs from its neighbours
      model_dmem[i] = dmem[i];
    end
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;  // reset clears the register file
    end
    repeat (10) @(negedge i_clk);
    i_rst = 1'b0;
    wait (done);
    $display("%0d check errors, %0d assertion failures", errors, dut.u_props.failures);
    if (errors == 0 && dut.u_props.failures == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
